//--- mips_isa_pkg.sv
package mips_isa_pkg;

  // primary opcodes, only the supported subset
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00, // r-type, funct decides
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0a,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LUI     = 6'h0f,
    OP_LB      = 6'h20,
    OP_LW      = 6'h23,
    OP_LBU     = 6'h24,
    OP_SW      = 6'h2b
  } opcode_e;

  // funct field of OP_SPECIAL
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_NOR  = 6'h27,
    FN_SLT  = 6'h2a,
    FN_SLTU = 6'h2b
  } funct_e;

  typedef struct packed {
    opcode_e    opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt; // only sll/srl use it
    funct_e     funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_e     opcode;
    logic [4:0]  rs;     // base reg for loads/stores
    logic [4:0]  rt;     // dest for imm ops and loads
    logic [15:0] imm16;
  } i_fmt_t;

  typedef struct packed {
    opcode_e     opcode;
    logic [25:0] target26; // word index inside the 256MB region
  } j_fmt_t;

  // one fetched word, three views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    j_fmt_t j;
  } instr_t;

  localparam logic [31:0] RESET_VECTOR = 32'hbfc0_0000; // boot rom
  localparam logic [4:0]  REG_V0       = 5'd2;  // result reg, tapped out
  localparam logic [4:0]  REG_RA       = 5'd31; // jal link

endpackage

//--- mips_ctrl_pkg.sv
package mips_ctrl_pkg;

  typedef enum logic [3:0] {
    ADD  = 4'd0, // also address calc
    SUB  = 4'd1, // also branch compare
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    NOR  = 4'd5,
    SLT  = 4'd6,
    SLTU = 4'd7,
    SLL  = 4'd8,
    SRL  = 4'd9,
    LUI  = 4'd10
  } alu_op_e;

  typedef enum logic [1:0] {
    LOAD_WORD   = 2'd0,
    LOAD_BYTE_S = 2'd1, // lb
    LOAD_BYTE_U = 2'd2  // lbu
  } load_kind_e;

  typedef enum logic [1:0] {
    PC_SEQ    = 2'd0,
    PC_BRANCH = 2'd1, // taken or not decided in datapath
    PC_JUMP   = 2'd2,
    PC_JREG   = 2'd3
  } pc_sel_e;

  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_MEM  = 2'd1,
    WB_LINK = 2'd2 // pc+4
  } wb_sel_e;

  // destination register select
  localparam logic [1:0] DST_RT = 2'd0;
  localparam logic [1:0] DST_RD = 2'd1;
  localparam logic [1:0] DST_RA = 2'd2;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       alu_src_imm;  // b operand from immediate
    logic       imm_zero_ext; // logical imm ops
    logic [1:0] reg_dst_sel;  // DST_*
    logic       reg_write;
    wb_sel_e    wb_sel;
    logic       mem_read;
    logic       mem_write;
    load_kind_e load_kind;
    logic       branch;
    logic       branch_ne;    // bne, inverts zero
    pc_sel_e    pc_sel;
  } ctrl_t;

endpackage

//--- alu.sv
module alu (
  input  logic [31:0]            a,
  input  logic [31:0]            b,
  input  logic [4:0]             shamt,
  input  mips_ctrl_pkg::alu_op_e op,
  output logic [31:0]            result,
  output logic                   zero
);

  logic [31:0] diff; // shared by sub and compares

  assign diff = a - b;

  always_comb begin
    case (op)
      mips_ctrl_pkg::ADD:  result = a + b;
      mips_ctrl_pkg::SUB:  result = diff;
      mips_ctrl_pkg::AND:  result = a & b;
      mips_ctrl_pkg::OR:   result = a | b;
      mips_ctrl_pkg::XOR:  result = a ^ b;
      mips_ctrl_pkg::NOR:  result = ~(a | b);
      mips_ctrl_pkg::SLT: begin
        // sign of diff, corrected when signs differ
        if (a[31] != b[31]) begin
          result = {31'd0, a[31]};
        end else begin
          result = {31'd0, diff[31]};
        end
      end
      mips_ctrl_pkg::SLTU: result = {31'd0, (a < b)};
      mips_ctrl_pkg::SLL:  result = b << shamt; // rt shifted, rs ignored
      mips_ctrl_pkg::SRL:  result = b >> shamt; // logical, zero fill
      mips_ctrl_pkg::LUI:  result = {b[15:0], 16'd0};
      default:             result = 32'd0;
    endcase
  end

  assign zero = (result == 32'd0); // beq/bne use sub

endmodule

//--- reg_file.sv
module reg_file (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata,
  input  logic [4:0]  raddr_a,
  input  logic [4:0]  raddr_b,
  output logic [31:0] rdata_a,
  output logic [31:0] rdata_b,
  output logic [31:0] v0
);

  logic [31:0] regs [32]; // gpr 0..31

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (we && waddr != 5'd0) begin // $zero is read only
      regs[waddr] <= wdata;
    end
  end

  // async read, no bypass, new value visible next cycle
  assign rdata_a = (raddr_a == 5'd0) ? 32'd0 : regs[raddr_a];
  assign rdata_b = (raddr_b == 5'd0) ? 32'd0 : regs[raddr_b];

  assign v0 = regs[mips_isa_pkg::REG_V0]; // for checking only

endmodule

//--- controller.sv
module controller (
  input  logic                 clk, // only clocks the check below
  input  mips_isa_pkg::instr_t instr,
  output mips_ctrl_pkg::ctrl_t ctrl
);

  mips_ctrl_pkg::alu_op_e r_op;    // alu op picked by funct
  logic                   r_alu;   // funct is an alu op
  logic                   r_shift; // sll / srl

  // r-type funct decode
  always_comb begin
    r_op    = mips_ctrl_pkg::ADD;
    r_alu   = 1'b1;
    r_shift = 1'b0;
    case (instr.r.funct)
      mips_isa_pkg::FN_ADDU: r_op = mips_ctrl_pkg::ADD;
      mips_isa_pkg::FN_SUBU: r_op = mips_ctrl_pkg::SUB;
      mips_isa_pkg::FN_AND:  r_op = mips_ctrl_pkg::AND;
      mips_isa_pkg::FN_OR:   r_op = mips_ctrl_pkg::OR;
      mips_isa_pkg::FN_XOR:  r_op = mips_ctrl_pkg::XOR;
      mips_isa_pkg::FN_NOR:  r_op = mips_ctrl_pkg::NOR;
      mips_isa_pkg::FN_SLT:  r_op = mips_ctrl_pkg::SLT;
      mips_isa_pkg::FN_SLTU: r_op = mips_ctrl_pkg::SLTU;
      mips_isa_pkg::FN_SLL: begin
        r_op    = mips_ctrl_pkg::SLL;
        r_shift = 1'b1;
      end
      mips_isa_pkg::FN_SRL: begin
        r_op    = mips_ctrl_pkg::SRL;
        r_shift = 1'b1;
      end
      default: r_alu = 1'b0; // jr, or unknown
    endcase
  end

  always_comb begin
    ctrl = '0; // no-op: seq pc, nothing written
    case (instr.i.opcode)
      mips_isa_pkg::OP_SPECIAL: begin
        if (instr.r.funct == mips_isa_pkg::FN_JR) begin
          ctrl.pc_sel = mips_ctrl_pkg::PC_JREG;
        end else if (r_alu && (r_shift || instr.r.shamt == 5'd0)) begin
          // shamt must be zero unless it is a shift
          ctrl.alu_op      = r_op;
          ctrl.reg_dst_sel = mips_ctrl_pkg::DST_RD;
          ctrl.reg_write   = 1'b1;
        end
      end
      mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_SLTI,
      mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI,
      mips_isa_pkg::OP_XORI, mips_isa_pkg::OP_LUI: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1; // into rt
        case (instr.i.opcode)
          mips_isa_pkg::OP_SLTI: ctrl.alu_op = mips_ctrl_pkg::SLT;
          mips_isa_pkg::OP_ANDI: ctrl.alu_op = mips_ctrl_pkg::AND;
          mips_isa_pkg::OP_ORI:  ctrl.alu_op = mips_ctrl_pkg::OR;
          mips_isa_pkg::OP_XORI: ctrl.alu_op = mips_ctrl_pkg::XOR;
          mips_isa_pkg::OP_LUI:  ctrl.alu_op = mips_ctrl_pkg::LUI;
          default:               ctrl.alu_op = mips_ctrl_pkg::ADD;
        endcase
        // logical ops take the imm unsigned
        ctrl.imm_zero_ext = !(instr.i.opcode inside {mips_isa_pkg::OP_ADDIU,
                                                     mips_isa_pkg::OP_SLTI});
      end
      mips_isa_pkg::OP_LW, mips_isa_pkg::OP_LB, mips_isa_pkg::OP_LBU: begin
        ctrl.alu_src_imm = 1'b1; // base + offset
        ctrl.reg_write   = 1'b1;
        ctrl.wb_sel      = mips_ctrl_pkg::WB_MEM;
        ctrl.mem_read    = 1'b1;
        case (instr.i.opcode)
          mips_isa_pkg::OP_LB:  ctrl.load_kind = mips_ctrl_pkg::LOAD_BYTE_S;
          mips_isa_pkg::OP_LBU: ctrl.load_kind = mips_ctrl_pkg::LOAD_BYTE_U;
          default:              ctrl.load_kind = mips_ctrl_pkg::LOAD_WORD;
        endcase
      end
      mips_isa_pkg::OP_SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1; // data is rt
      end
      mips_isa_pkg::OP_BEQ, mips_isa_pkg::OP_BNE: begin
        ctrl.alu_op    = mips_ctrl_pkg::SUB; // rs - rt, zero on equal
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = (instr.i.opcode == mips_isa_pkg::OP_BNE);
        ctrl.pc_sel    = mips_ctrl_pkg::PC_BRANCH;
      end
      mips_isa_pkg::OP_J: ctrl.pc_sel = mips_ctrl_pkg::PC_JUMP;
      mips_isa_pkg::OP_JAL: begin
        ctrl.pc_sel      = mips_ctrl_pkg::PC_JUMP;
        ctrl.reg_dst_sel = mips_ctrl_pkg::DST_RA;
        ctrl.reg_write   = 1'b1;
        ctrl.wb_sel      = mips_ctrl_pkg::WB_LINK;
      end
      default: ; // unsupported, stays no-op
    endcase
  end

  // one data port, never both strobes in one cycle
  a_mem_excl: assert property (@(posedge clk) !(ctrl.mem_read && ctrl.mem_write))
    else $error("controller: load and store decoded together");

endmodule

//--- datapath.sv
module datapath (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 clk_enable,
  input  mips_ctrl_pkg::ctrl_t ctrl,
  input  mips_isa_pkg::instr_t instr,
  output logic [31:0]          instr_address,
  input  logic [31:0]          data_readdata,
  output logic [31:0]          data_address,
  output logic [31:0]          data_writedata,
  output logic                 data_read,
  output logic                 data_write,
  output logic                 active,
  output logic [31:0]          register_v0
);

  logic [31:0] pc;
  logic [31:0] pc_plus4;
  logic [31:0] pc_next;
  logic [31:0] branch_target;
  logic [31:0] jump_target;
  logic        branch_taken;
  logic        step;        // this edge retires an instruction
  logic [31:0] imm_ext;
  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic        alu_zero;
  logic [7:0]  load_byte;
  logic [31:0] load_data;
  logic [31:0] wb_data;
  logic [4:0]  wb_addr;

  assign step = active && clk_enable; // halted or frozen: nothing moves

  // pc and halt flag
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= mips_isa_pkg::RESET_VECTOR;
      active <= 1'b1;
    end else if (step) begin
      pc     <= pc_next;
      active <= (pc_next != 32'd0); // falls on the jump to 0
    end
  end

  assign instr_address = pc;

  // next pc, no delay slot
  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr.j.target26, 2'b00};
  assign branch_taken  = ctrl.branch && (alu_zero ^ ctrl.branch_ne);

  always_comb begin
    case (ctrl.pc_sel)
      mips_ctrl_pkg::PC_BRANCH: pc_next = branch_taken ? branch_target : pc_plus4;
      mips_ctrl_pkg::PC_JUMP:   pc_next = jump_target;
      mips_ctrl_pkg::PC_JREG:   pc_next = rs_data; // jr
      default:                  pc_next = pc_plus4;
    endcase
  end

  // operands
  assign imm_ext = ctrl.imm_zero_ext ? {16'd0, instr.i.imm16}
                                     : {{16{instr.i.imm16[15]}}, instr.i.imm16};
  assign alu_b   = ctrl.alu_src_imm ? imm_ext : rt_data;

  alu u_alu (
    .a      (rs_data),
    .b      (alu_b),
    .shamt  (instr.r.shamt),
    .op     (ctrl.alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // data port, strobes only on a retiring cycle
  assign data_address   = alu_result;
  assign data_writedata = rt_data;
  assign data_read      = ctrl.mem_read && step;
  assign data_write     = ctrl.mem_write && step;

  // byte lane by low address bits, lane 0 = bits 7:0
  assign load_byte = data_readdata[{data_address[1:0], 3'b000} +: 8];

  always_comb begin
    case (ctrl.load_kind)
      mips_ctrl_pkg::LOAD_BYTE_S: load_data = {{24{load_byte[7]}}, load_byte};
      mips_ctrl_pkg::LOAD_BYTE_U: load_data = {24'd0, load_byte};
      default:                    load_data = data_readdata; // aligned word
    endcase
  end

  // write back
  always_comb begin
    case (ctrl.wb_sel)
      mips_ctrl_pkg::WB_MEM:  wb_data = load_data;
      mips_ctrl_pkg::WB_LINK: wb_data = pc_plus4; // jal return addr
      default:                wb_data = alu_result;
    endcase
  end

  always_comb begin
    case (ctrl.reg_dst_sel)
      mips_ctrl_pkg::DST_RD: wb_addr = instr.r.rd;
      mips_ctrl_pkg::DST_RA: wb_addr = mips_isa_pkg::REG_RA;
      default:               wb_addr = instr.i.rt; // DST_RT
    endcase
  end

  reg_file u_reg_file (
    .clk     (clk),
    .arst_n  (arst_n),
    .we      (ctrl.reg_write && step),
    .waddr   (wb_addr),
    .wdata   (wb_data),
    .raddr_a (instr.r.rs),
    .raddr_b (instr.r.rt),
    .rdata_a (rs_data),
    .rdata_b (rt_data),
    .v0      (register_v0)
  );

  // fetch stays word aligned while running
  a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
    active |-> (instr_address[1:0] == 2'b00))
    else $error("datapath: misaligned fetch address");

  // freeze holds the pc across the edge
  a_pc_frozen: assert property (@(posedge clk) disable iff (!arst_n)
    !clk_enable |=> $stable(instr_address))
    else $error("datapath: pc moved while clk_enable low");

endmodule

//--- mips_cpu_harvard.sv
module mips_cpu_harvard (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        clk_enable,
  output logic        active,
  output logic [31:0] register_v0,

  // instruction port, data back in the same cycle
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,

  // data port, read data same cycle, store at the edge
  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);

  mips_isa_pkg::instr_t instr; // fetched word, decoded views
  mips_ctrl_pkg::ctrl_t ctrl;

  assign instr = mips_isa_pkg::instr_t'(instr_readdata);

  controller u_controller (
    .clk   (clk),
    .instr (instr),
    .ctrl  (ctrl)
  );

  datapath u_datapath (
    .clk            (clk),
    .arst_n         (arst_n),
    .clk_enable     (clk_enable),
    .ctrl           (ctrl),
    .instr          (instr),
    .instr_address  (instr_address),
    .data_readdata  (data_readdata),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_read      (data_read),
    .data_write     (data_write),
    .active         (active),
    .register_v0    (register_v0)
  );

endmodule

//--- mips_cpu_harvard_tb.sv
module mips_cpu_harvard_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_ROWS = 7;
  localparam int N_RUNS = 2 * N_ROWS; // random freeze pass, then steady pass
  localparam logic [31:0] RAM_BASE = 32'h0000_1000;
  localparam logic [31:0] OUTSIDE_WORD = 32'hac02_0000; // sw $2, 0($0)

  logic        clk;
  logic        arst_n;
  logic        clk_enable;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;

  logic [31:0] rom [16];      // program of the current row
  logic [31:0] ram [64];      // data ram at RAM_BASE
  logic [31:0] ram_init [64]; // image copied in during reset
  logic [31:0] rom_off;
  logic [31:0] ram_off;
  logic [31:0] rng;           // xorshift state

  string       names [N_ROWS];
  logic [31:0] prog [N_ROWS][12];
  int          kind [N_ROWS];  // 0 fixed v0, 1 load mix, 2 store and reload
  logic [31:0] exp_v0 [N_ROWS];

  mips_cpu_harvard u_mips_cpu_harvard (
    .clk            (clk),
    .arst_n         (arst_n),
    .clk_enable     (clk_enable),
    .active         (active),
    .register_v0    (register_v0),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  always #50 clk = ~clk;

  // both memories answer in the same cycle
  assign rom_off        = instr_address - mips_isa_pkg::RESET_VECTOR;
  // outside the rom, a halted cpu keeps fetching a store
  assign instr_readdata = (rom_off < 32'd64) ? rom[rom_off[5:2]] : OUTSIDE_WORD;
  assign ram_off        = data_address - RAM_BASE;
  // read data only under the strobe
  assign data_readdata  = (data_read && ram_off < 32'd256) ? ram[ram_off[7:2]] : 32'd0;

  always @(posedge clk) begin
    if (!arst_n) begin
      for (int i = 0; i < 64; i++) begin
        ram[i] <= ram_init[i]; // fresh image each program
      end
    end else if (data_write && ram_off < 32'd256) begin
      ram[ram_off[7:2]] <= data_writedata;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input logic [4:0] sh,
                                        input logic [5:0] fn);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // jump to word idx of the program
  function automatic logic [31:0] enc_j(input logic [5:0] op, input int idx);
    logic [31:0] word;
    word = (mips_isa_pkg::RESET_VECTOR >> 2) + 32'(idx);
    return {op, word[25:0]};
  endfunction

  function automatic logic [31:0] sext8(input logic [7:0] b);
    return {{24{b[7]}}, b};
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error %s expected %08h actual %08h", name, expected, actual);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // no strobe from a halted or frozen cpu
  always @(negedge clk) begin
    if (arst_n && (!active || !clk_enable)) begin
      check("data_write while idle", 32'd0, {31'd0, data_write});
      check("data_read while idle", 32'd0, {31'd0, data_read});
    end
  end

  initial begin
    #(N_RUNS * 40 * 100);
    $display("The CPU never halted before the watchdog ran out");
    $display("Finished with errors");
    $fatal(1);
  end

  task automatic run_row(input int r, input bit rand_en);
    logic [31:0] snap_pc;
    logic [31:0] snap_v0;
    logic [31:0] w;
    logic [31:0] expected;
    logic        en_at;
    bit          done;
    string       tag;
    tag = $sformatf("%s/%s", names[r], rand_en ? "freeze" : "steady");
    for (int i = 0; i < 16; i++) begin
      rom[i] = (i < 12) ? prog[r][i] : enc_r(5'd0, 5'd0, 5'd0, 5'd0, mips_isa_pkg::FN_JR);
    end
    for (int i = 0; i < 64; i++) begin
      rng = xorshift(rng);
      ram_init[i] = rng;
    end
    @(posedge clk);
    arst_n     <= 1'b0;
    clk_enable <= 1'b1;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    en_at = 1'b1;
    snap_pc = '0;
    snap_v0 = '0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (!active) begin
        done = 1'b1;
      end else begin
        if (!en_at) begin // frozen edge just passed
          check({tag, " pc frozen"}, snap_pc, instr_address);
          check({tag, " v0 frozen"}, snap_v0, register_v0);
        end
        snap_pc = instr_address;
        snap_v0 = register_v0;
        en_at   = clk_enable;
        @(posedge clk);
        rng = xorshift(rng);
        clk_enable <= rand_en ? ((rng & 32'd3) != 32'd0) : 1'b1;
      end
    end
    check({tag, " halt pc"}, 32'd0, instr_address);
    @(posedge clk);
    clk_enable <= 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check({tag, " pc after halt"}, 32'd0, instr_address);
    check({tag, " active after halt"}, 32'd0, {31'd0, active});
    case (kind[r])
      1: begin
        w = ram_init[5]; // word at 0x1014
        expected = w + sext8(w[15:8]);
        expected = expected ^ {24'd0, w[23:16]};
        expected = expected - sext8(w[31:24]);
        expected = expected ^ {24'd0, w[7:0]};
      end
      2: begin
        expected = ram_init[9] ^ 32'h0000_5a5a; // xori zero-extends
        check({tag, " ram word"}, expected, ram[8]);
      end
      default: expected = exp_v0[r];
    endcase
    check({tag, " v0"}, expected, register_v0);
  endtask

  task automatic set_row(input int r, input string name, input int k, input logic [31:0] v0);
    names[r]  = name;
    kind[r]   = k;
    exp_v0[r] = v0;
    for (int i = 0; i < 12; i++) begin
      prog[r][i] = enc_r(5'd0, 5'd0, 5'd0, 5'd0, mips_isa_pkg::FN_JR); // pad with halt
    end
  endtask

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    clk_enable = 1'b0;
    rng        = 32'd22;
    for (int i = 0; i < 64; i++) begin
      ram_init[i] = '0;
    end
    set_row(0, "alu_r1", 0, 32'h0000_0129);
    prog[0][0] = enc_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd8, 16'h1234);
    prog[0][1] = enc_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd9, 16'hfffd); // -3
    prog[0][2] = enc_r(5'd8, 5'd9, 5'd2, 5'd0, mips_isa_pkg::FN_ADDU);  // 1231
    prog[0][3] = enc_r(5'd8, 5'd9, 5'd10, 5'd0, mips_isa_pkg::FN_SUBU); // 1237
    prog[0][4] = enc_r(5'd2, 5'd10, 5'd2, 5'd0, mips_isa_pkg::FN_XOR);  // 6
    prog[0][5] = enc_r(5'd8, 5'd9, 5'd11, 5'd0, mips_isa_pkg::FN_NOR);  // 2
    prog[0][6] = enc_r(5'd2, 5'd11, 5'd2, 5'd0, mips_isa_pkg::FN_OR);   // 6
    prog[0][7] = enc_r(5'd8, 5'd9, 5'd12, 5'd0, mips_isa_pkg::FN_AND);  // 1234
    prog[0][8] = enc_r(5'd0, 5'd12, 5'd12, 5'd4, mips_isa_pkg::FN_SRL); // 123
    prog[0][9] = enc_r(5'd2, 5'd12, 5'd2, 5'd0, mips_isa_pkg::FN_ADDU);
    set_row(1, "alu_r2", 0, 32'h0000_0020);
    prog[1][0] = enc_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd8, 16'h1234);
    prog[1][1] = enc_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd9, 16'hfffd);
    prog[1][2] = enc_r(5'd9, 5'd8, 5'd12, 5'd0, mips_isa_pkg::FN_SLT);  // 1
    prog[1][3] = enc_r(5'd8, 5'd9, 5'd13, 5'd0, mips_isa_pkg::FN_SLTU); // 1
    prog[1][4] = enc_r(5'd8, 5'd9, 5'd14, 5'd0, mips_isa_pkg::FN_SLT);  // 0
    prog[1][5] = enc_r(5'd12, 5'd13, 5'd2, 5'd0, mips_isa_pkg::FN_ADDU);
    prog[1][6] = enc_r(5'd2, 5'd14, 5'd2, 5'd0, mips_isa_pkg::FN_ADDU);
    prog[1][7] = enc_r(5'd0, 5'd2, 5'd2, 5'd4, mips_isa_pkg::FN_SLL);   // 20
    prog[1][8] = enc_r(5'd8, 5'd8, 5'd0, 5'd0, mips_isa_pkg::FN_ADDU);  // $zero stays 0
    prog[1][9] = enc_r(5'd2, 5'd0, 5'd2, 5'd0, mips_isa_pkg::FN_ADDU);
    set_row(2, "alu_imm", 0, 32'h0000_0fe1);
    prog[2][0]  = enc_i(mips_isa_pkg::OP_LUI, 5'd0, 5'd8, 16'h8001);
    prog[2][1]  = enc_i(mips_isa_pkg::OP_ORI, 5'd8, 5'd8, 16'hf00f);   // 8001f00f
    prog[2][2]  = enc_i(mips_isa_pkg::OP_ANDI, 5'd8, 5'd9, 16'hff0f);  // f00f
    prog[2][3]  = enc_i(mips_isa_pkg::OP_XORI, 5'd9, 5'd9, 16'hffff);  // 0ff0
    prog[2][4]  = enc_i(mips_isa_pkg::OP_SLTI, 5'd8, 5'd10, 16'h0001); // 1
    prog[2][5]  = enc_i(mips_isa_pkg::OP_SLTI, 5'd9, 5'd11, 16'hffff); // 0
    prog[2][6]  = enc_i(mips_isa_pkg::OP_ADDIU, 5'd9, 5'd2, 16'hfff0); // 0fe0
    prog[2][7]  = enc_r(5'd2, 5'd10, 5'd2, 5'd0, mips_isa_pkg::FN_ADDU);
    prog[2][8]  = enc_r(5'd2, 5'd11, 5'd2, 5'd0, mips_isa_pkg::FN_ADDU);
    prog[2][9]  = enc_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd0, 16'h0005);
    prog[2][10] = enc_r(5'd2, 5'd0, 5'd2, 5'd0, mips_isa_pkg::FN_ADDU);
    set_row(3, "loads", 1, 32'd0);
    prog[3][0] = enc_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd8, 16'h1014);
    prog[3][1] = enc_i(mips_isa_pkg::OP_LW, 5'd8, 5'd9, 16'd0);
    prog[3][2] = enc_i(mips_isa_pkg::OP_LB, 5'd8, 5'd10, 16'd1);
    prog[3][3] = enc_i(mips_isa_pkg::OP_LBU, 5'd8, 5'd11, 16'd2);
    prog[3][4] = enc_i(mips_isa_pkg::OP_LB, 5'd8, 5'd12, 16'd3);
    prog[3][5] = enc_i(mips_isa_pkg::OP_LBU, 5'd8, 5'd13, 16'd0);
    prog[3][6] = enc_r(5'd9, 5'd10, 5'd2, 5'd0, mips_isa_pkg::FN_ADDU);
    prog[3][7] = enc_r(5'd2, 5'd11, 5'd2, 5'd0, mips_isa_pkg::FN_XOR);
    prog[3][8] = enc_r(5'd2, 5'd12, 5'd2, 5'd0, mips_isa_pkg::FN_SUBU);
    prog[3][9] = enc_r(5'd2, 5'd13, 5'd2, 5'd0, mips_isa_pkg::FN_XOR);
    set_row(4, "store", 2, 32'd0);
    prog[4][0] = enc_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd8, 16'h1020);
    prog[4][1] = enc_i(mips_isa_pkg::OP_LW, 5'd8, 5'd9, 16'd4);       // word 9
    prog[4][2] = enc_i(mips_isa_pkg::OP_XORI, 5'd9, 5'd10, 16'h5a5a);
    prog[4][3] = enc_i(mips_isa_pkg::OP_SW, 5'd8, 5'd10, 16'd0);      // word 8
    prog[4][4] = enc_i(mips_isa_pkg::OP_LW, 5'd8, 5'd2, 16'd0);
    set_row(5, "branch", 0, 32'h0000_0011);
    prog[5][0] = enc_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd8, 16'd1);
    prog[5][1] = enc_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd9, 16'd1);
    prog[5][2] = enc_i(mips_isa_pkg::OP_BEQ, 5'd8, 5'd9, 16'd1);      // taken
    prog[5][3] = enc_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0100);
    prog[5][4] = enc_i(mips_isa_pkg::OP_BNE, 5'd8, 5'd9, 16'd1);      // not taken
    prog[5][5] = enc_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0001);
    prog[5][6] = enc_i(mips_isa_pkg::OP_BNE, 5'd8, 5'd0, 16'd1);      // taken
    prog[5][7] = enc_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0200);
    prog[5][8] = enc_i(mips_isa_pkg::OP_BEQ, 5'd8, 5'd0, 16'd1);      // not taken
    prog[5][9] = enc_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0010);
    set_row(6, "jump", 0, 32'hbfc0_000f);
    prog[6][0] = enc_j(mips_isa_pkg::OP_J, 2);
    prog[6][1] = enc_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0100); // skipped
    prog[6][2] = enc_j(mips_isa_pkg::OP_JAL, 5);                       // ra = bfc0000c
    prog[6][3] = enc_r(5'd2, 5'd31, 5'd2, 5'd0, mips_isa_pkg::FN_ADDU);
    prog[6][5] = enc_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0003);
    prog[6][6] = enc_r(5'd31, 5'd0, 5'd0, 5'd0, mips_isa_pkg::FN_JR); // back to 3
    for (int pass = 0; pass < 2; pass++) begin
      for (int r = 0; r < N_ROWS; r++) begin
        run_row(r, pass == 0);
      end
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- build.f
mips_isa_pkg.sv
mips_ctrl_pkg.sv
alu.sv
reg_file.sv
controller.sv
datapath.sv
mips_cpu_harvard.sv
mips_cpu_harvard_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator and run the CPU testbench
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module mips_cpu_harvard_tb \
  -f build.f \
  -o mips_cpu_harvard_sim

# a fatal stop exits non-zero, the log decides the verdict
./obj_dir/mips_cpu_harvard_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
